// ==== common/ig_pkg.sv ====
package ig_pkg;

    // --------------------------------------------------
    // image geometry
    // --------------------------------------------------
    localparam int IMG_W   = 256;
    localparam int IMG_H   = 256;
    localparam int NUM_PIX = IMG_W * IMG_H;

    localparam int PIX_W  = 8;
    localparam int GRAD_W = 10;

    // --------------------------------------------------
    // vector types
    // --------------------------------------------------
    typedef logic [PIX_W-1:0] pix_t;

    // raster address, row in the upper byte and column in the lower
    typedef logic [$clog2(NUM_PIX)-1:0] addr_t;

    // square image, so the row counters use this type too
    typedef logic [$clog2(IMG_W)-1:0] col_t;

    typedef logic signed [GRAD_W-1:0] grad_t;

    // Gx in the upper term, Gy in the lower term
    typedef logic [2*GRAD_W-1:0] grad_pair_t;

    // --------------------------------------------------
    // state machines
    // --------------------------------------------------
    typedef enum logic {
        FETCH_READ,
        FETCH_IDLE
    } fetch_state_t;

    typedef enum logic [1:0] {
        BUF_FILL,
        BUF_STREAM,
        BUF_FLUSH,
        BUF_IDLE
    } buf_state_t;

endpackage

// ==== pixel_fetch/pixel_fetch.sv ====
`timescale 1ns/100ps

module pixel_fetch import ig_pkg::*; (
    input  logic  clk,
    input  logic  reset,

    // image memory read port
    output logic  img_rd,
    output addr_t img_addr,
    input  pix_t  img_di,

    // pixel stream to the row buffer
    output logic  pix_valid,
    output pix_t  pix_data
);

    fetch_state_t state;
    logic         rd_q;
    logic         last_addr;

    assign last_addr = (img_addr == addr_t'(NUM_PIX - 1));

    // --------------------------------------------------
    // address generation
    // --------------------------------------------------
    // img_rd comes up on the first edge out of reset and then stays
    // high while the address walks the whole image once
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= FETCH_READ;
            img_rd   <= 1'b0;
            img_addr <= '0;
        end else begin
            case (state)
                FETCH_READ: begin
                    if (img_rd) begin
                        img_addr <= img_addr + addr_t'(1);
                        if (last_addr) begin
                            img_rd <= 1'b0;
                            state  <= FETCH_IDLE;
                        end
                    end else begin
                        img_rd <= 1'b1;
                    end
                end
                FETCH_IDLE: begin
                    // run finished, only reset starts a new one
                    img_rd <= 1'b0;
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // read return
    // --------------------------------------------------
    // memory answers one cycle after the address, so a delayed
    // copy of img_rd marks the cycles where img_di is valid
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q      <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            rd_q      <= img_rd;
            pix_valid <= rd_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_q) begin
            pix_data <= img_di;
        end
    end

endmodule

// ==== row_buffer/row_buffer.sv ====
`timescale 1ns/100ps

module row_buffer import ig_pkg::*; (
    input  logic clk,
    input  logic reset,

    // raster pixel stream
    input  logic pix_valid,
    input  pix_t pix_data,

    // neighbourhood of one centre pixel
    output logic win_valid,
    output pix_t win_cur,
    output pix_t win_right,
    output pix_t win_below
);

    buf_state_t state;
    col_t       col;
    col_t       col_next;
    col_t       row;
    logic       last_col;
    logic       last_row;

    // one image row, entry x holds the newest pixel seen in column x
    pix_t       row_mem [IMG_W];

    logic       store_en;
    logic       emit_stream;
    logic       emit_flush;
    logic       emit;
    pix_t       rd_cur;
    pix_t       rd_right;
    pix_t       below;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    assign col_next = col + col_t'(1);
    assign last_col = (col == col_t'(IMG_W - 1));
    assign last_row = (row == col_t'(IMG_H - 1));

    assign store_en    = pix_valid && (state == BUF_FILL || state == BUF_STREAM);
    assign emit_stream = pix_valid && (state == BUF_STREAM);
    assign emit_flush  = (state == BUF_FLUSH);
    assign emit        = emit_stream || emit_flush;

    // right neighbour wraps to entry 0 at the last column,
    // grad_calc masks that term anyway
    assign rd_cur   = row_mem[col];
    assign rd_right = row_mem[col_next];

    // while flushing there is no row below, replay the stored pixel
    assign below = emit_flush ? rd_cur : pix_data;

    // --------------------------------------------------
    // control FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= BUF_FILL;
            col       <= '0;
            row       <= '0;
            win_valid <= 1'b0;
        end else begin
            win_valid <= emit;
            case (state)
                BUF_FILL: begin
                    // row 0 only primes the store
                    if (pix_valid) begin
                        col <= col_next;
                        if (last_col) begin
                            row   <= row + col_t'(1);
                            state <= BUF_STREAM;
                        end
                    end
                end
                BUF_STREAM: begin
                    if (pix_valid) begin
                        col <= col_next;
                        if (last_col) begin
                            row <= row + col_t'(1);
                            if (last_row) begin
                                state <= BUF_FLUSH;
                            end
                        end
                    end
                end
                BUF_FLUSH: begin
                    // store now holds row 255, one window per cycle
                    col <= col_next;
                    if (last_col) begin
                        state <= BUF_IDLE;
                    end
                end
                BUF_IDLE: begin
                    col <= '0;
                end
                default: begin
                    state <= BUF_IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // row store and window registers
    // --------------------------------------------------
    // read of entry x sees the old row, the write lands after it
    always_ff @(posedge clk) begin
        if (store_en) begin
            row_mem[col] <= pix_data;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            win_cur   <= rd_cur;
            win_right <= rd_right;
            win_below <= below;
        end
    end

endmodule

// ==== grad_calc/grad_calc.sv ====
`timescale 1ns/100ps

module grad_calc import ig_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    // window from the row buffer
    input  logic       win_valid,
    input  pix_t       win_cur,
    input  pix_t       win_right,
    input  pix_t       win_below,

    // gradient memory write port
    output logic       grad_wr,
    output addr_t      grad_addr,
    output grad_pair_t grad_do,
    output logic       done
);

    addr_t wr_cnt;
    col_t  col;
    col_t  row;
    grad_t gx;
    grad_t gy;

    // windows arrive in raster order, so the counter is the address
    assign col = wr_cnt[$bits(col_t)-1:0];
    assign row = wr_cnt[$bits(addr_t)-1:$bits(col_t)];

    // --------------------------------------------------
    // forward differences
    // --------------------------------------------------
    // zero-extend both pixels to the term width, then subtract
    always_comb begin
        if (col == col_t'(IMG_W - 1)) begin
            gx = '0;
        end else begin
            gx = grad_t'({{(GRAD_W - PIX_W){1'b0}}, win_right})
               - grad_t'({{(GRAD_W - PIX_W){1'b0}}, win_cur});
        end

        if (row == col_t'(IMG_H - 1)) begin
            gy = '0;
        end else begin
            gy = grad_t'({{(GRAD_W - PIX_W){1'b0}}, win_below})
               - grad_t'({{(GRAD_W - PIX_W){1'b0}}, win_cur});
        end
    end

    // --------------------------------------------------
    // write-back and done
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_cnt  <= '0;
            grad_wr <= 1'b0;
            done    <= 1'b0;
        end else begin
            grad_wr <= win_valid;
            if (win_valid) begin
                wr_cnt <= wr_cnt + addr_t'(1);
            end
            // last word goes out this cycle, flag it on the next
            if (grad_wr && grad_addr == addr_t'(NUM_PIX - 1)) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            grad_addr <= wr_cnt;
            grad_do   <= {gx, gy};
        end
    end

endmodule

// ==== logic/ig_top.sv ====
`timescale 1ns/100ps

module ig_top import ig_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    // image memory
    output logic       img_rd,
    output addr_t      img_addr,
    input  pix_t       img_di,

    // gradient memory
    output logic       grad_wr,
    output addr_t      grad_addr,
    output grad_pair_t grad_do,

    output logic       done
);

    // fetch to buffer
    logic pix_valid;
    pix_t pix_data;

    // buffer to calc
    logic win_valid;
    pix_t win_cur;
    pix_t win_right;
    pix_t win_below;

    pixel_fetch pixel_fetch_i (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .pix_valid (pix_valid),
        .pix_data  (pix_data)
    );

    row_buffer row_buffer_i (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .win_valid (win_valid),
        .win_cur   (win_cur),
        .win_right (win_right),
        .win_below (win_below)
    );

    grad_calc grad_calc_i (
        .clk       (clk),
        .reset     (reset),
        .win_valid (win_valid),
        .win_cur   (win_cur),
        .win_right (win_right),
        .win_below (win_below),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

endmodule

// ==== dv/img_mem_model.sv ====
`timescale 1ns/100ps

module img_mem_model import ig_pkg::*; (
    input  logic  clk,

    // read port, data returns one cycle after the address
    input  logic  rd,
    input  addr_t addr,
    output pix_t  dout
);

    pix_t mem [NUM_PIX];

    initial begin
        dout = '0;
    end

    // --------------------------------------------------
    // registered read
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rd) begin
            dout <= mem[addr];
        end
    end

    // --------------------------------------------------
    // backdoor load
    // --------------------------------------------------
    // only used while the engine is idle or held in reset
    task write_pixel(input addr_t a, input pix_t value);
        mem[a] = value;
    endtask

endmodule

// ==== dv/ig_tb.sv ====
`timescale 1ns/100ps

module ig_tb import ig_pkg::*; ();

    localparam int     RESET_CYCLES = 5;
    localparam int     HOLD_CYCLES  = 20;
    localparam int     RUN_LIMIT    = NUM_PIX + 600;
    localparam longint WATCHDOG_NS  = longint'(4) * RUN_LIMIT * 40 * 2;
    localparam int     MAX_SHOWN    = 20;
    localparam int     IMG_RANDOM   = 0;
    localparam int     IMG_FLAT     = 1;
    localparam int     IMG_CHECKER  = 2;

    logic       clk = 1'b0;
    logic       reset;
    logic       img_rd;
    addr_t      img_addr;
    pix_t       img_di;
    logic       grad_wr;
    addr_t      grad_addr;
    grad_pair_t grad_do;
    logic       done;

    // image as loaded, gradient memory as written, write hits per address
    pix_t       img      [NUM_PIX];
    grad_pair_t grad_mem [NUM_PIX];
    int         wr_hits  [NUM_PIX];

    string cur_test;
    int    run_errs  = 0;
    int    mon_errs  = 0;
    int    rd_count  = 0;
    int    wr_count  = 0;
    addr_t rd_next   = '0;
    addr_t wr_next   = '0;
    logic  rst_prev  = 1'b0;
    logic  rst_prev2 = 1'b0;
    logic  done_due  = 1'b0;
    logic  done_seen = 1'b0;

    always #20 clk = ~clk;

    ig_top ig_top_i (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    img_mem_model img_mem_i (
        .clk  (clk),
        .rd   (img_rd),
        .addr (img_addr),
        .dout (img_di)
    );

    // --------------------------------------------------
    // reference model and compare tasks
    // --------------------------------------------------
    // forward differences, missing neighbour at the border gives zero
    function automatic grad_pair_t ref_grad(input addr_t a);
        int i;
        int gx;
        int gy;
        i  = int'(a);
        gx = 0;
        gy = 0;
        if (i % IMG_W != IMG_W - 1) begin
            gx = int'(img[addr_t'(i + 1)]) - int'(img[a]);
        end
        if (i / IMG_W != IMG_H - 1) begin
            gy = int'(img[addr_t'(i + IMG_W)]) - int'(img[a]);
        end
        return {grad_t'(gx), grad_t'(gy)};
    endfunction

    task automatic check_grad(input string name, input addr_t a,
                              input grad_pair_t exp, input grad_pair_t act);
        if (act !== exp) begin
            run_errs++;
            if (run_errs <= MAX_SHOWN) begin
                $display("Mismatch %s addr %h: expected %h, actual %h", name, a, exp, act);
            end
        end
    endtask

    task automatic check_count(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            run_errs++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_level(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            mon_errs++;
            $display("Mismatch %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    // --------------------------------------------------
    // bus monitor
    // --------------------------------------------------
    // samples at the rising edge, so it sees the values of the last cycle
    always @(posedge clk) begin
        if (rst_prev) begin
            check_level("img_rd in reset", 1'b0, img_rd);
            check_level("grad_wr in reset", 1'b0, grad_wr);
            check_level("done in reset", 1'b0, done);
        end else if (rst_prev2) begin
            check_level("img_rd after reset", 1'b1, img_rd);
            check_level("grad_wr after reset", 1'b0, grad_wr);
            check_level("done after reset", 1'b0, done);
        end
        if (done_due) begin
            check_level("done after last write", 1'b1, done);
            done_due = 1'b0;
        end
        if (done_seen && done !== 1'b1 && !rst_prev) begin
            mon_errs++;
            $display("ERROR: test %s, done fell before the next reset", cur_test);
        end

        if (img_rd === 1'b1) begin
            if (img_addr !== rd_next) begin
                mon_errs++;
                $display("ERROR: test %s, read address %h out of order, expected %h",
                         cur_test, img_addr, rd_next);
            end
            rd_next = img_addr + addr_t'(1);
            rd_count++;
        end

        if (grad_wr === 1'b1) begin
            if (done === 1'b1) begin
                mon_errs++;
                $display("ERROR: test %s, write to %h after done", cur_test, grad_addr);
            end
            if (grad_addr !== wr_next) begin
                mon_errs++;
                $display("ERROR: test %s, write address %h out of order, expected %h",
                         cur_test, grad_addr, wr_next);
            end
            if (wr_hits[grad_addr] != 0) begin
                mon_errs++;
                $display("ERROR: test %s, address %h written twice", cur_test, grad_addr);
            end
            wr_hits[grad_addr]++;
            grad_mem[grad_addr] = grad_do;
            wr_next = grad_addr + addr_t'(1);
            wr_count++;
            if (grad_addr == addr_t'(NUM_PIX - 1)) begin
                done_due = 1'b1;
            end
        end

        // fresh bookkeeping for each run
        if (reset) begin
            if (!rst_prev) begin
                for (int i = 0; i < NUM_PIX; i++) begin
                    wr_hits[addr_t'(i)] = 0;
                end
            end
            rd_count  = 0;
            wr_count  = 0;
            rd_next   = '0;
            wr_next   = '0;
            done_due  = 1'b0;
            done_seen = 1'b0;
        end else if (done === 1'b1) begin
            done_seen = 1'b1;
        end
        rst_prev2 = rst_prev;
        rst_prev  = reset;
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    task automatic fill_image(input int kind);
        pix_t v;
        for (int i = 0; i < NUM_PIX; i++) begin
            case (kind)
                IMG_FLAT:    v = 8'd77;
                IMG_CHECKER: v = (((i ^ (i >> 8)) & 1) != 0) ? 8'hff : 8'h00;
                default:     v = pix_t'($urandom);
            endcase
            img[addr_t'(i)] = v;
            img_mem_i.write_pixel(addr_t'(i), v);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            run_errs++;
            $display("ERROR: test %s, done did not rise within %0d cycles", cur_test, RUN_LIMIT);
        end
    endtask

    task automatic run_test(input string name, input int kind);
        addr_t a;
        cur_test = name;
        fill_image(kind);
        apply_reset();
        wait_done();
        // the monitor flags done if it drops during this hold
        repeat (HOLD_CYCLES) @(posedge clk);
        check_count({name, " last read index"}, addr_t'(NUM_PIX - 1), addr_t'(rd_count - 1));
        check_count({name, " last write index"}, addr_t'(NUM_PIX - 1), addr_t'(wr_count - 1));
        for (int i = 0; i < NUM_PIX; i++) begin
            a = addr_t'(i);
            if (wr_hits[a] == 0) begin
                run_errs++;
                if (run_errs <= MAX_SHOWN) begin
                    $display("ERROR: test %s, address %h was never written", name, a);
                end
            end else begin
                check_grad(name, a, ref_grad(a), grad_mem[a]);
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        void'($urandom(32'hb8deef0d));
        run_test("random", IMG_RANDOM);
        run_test("flat", IMG_FLAT);
        run_test("checker", IMG_CHECKER);
        // second random image through a plain reset
        run_test("random_rerun", IMG_RANDOM);
        $display("errors: %0d in result checks, %0d in protocol checks", run_errs, mon_errs);
        if (run_errs == 0 && mon_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // four runs of a full image with margin
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== all.f ====
common/ig_pkg.sv
pixel_fetch/pixel_fetch.sv
row_buffer/row_buffer.sv
grad_calc/grad_calc.sv
logic/ig_top.sv
dv/img_mem_model.sv
dv/ig_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the gradient engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=ig_tb_sim
LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module ig_tb \
    --Mdir "$BUILD_DIR" \
    -o "$SIM_BIN" \
    -f all.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
